// File: Bender.yml
package:
  name: axis_accelerator

sources:
  - hdl/accel_pkg.sv
  - hdl/accel_ctrl_pkg.sv
  - hdl/input_pipe.sv
  - hdl/conv_engine.sv
  - hdl/lrelu_engine.sv
  - hdl/maxpool_engine.sv
  - hdl/axis_accelerator.sv
  - target: test
    files:
      - test/axis_accelerator_assert.sv
      - test/axis_accelerator_tb.sv

// File: axis_accelerator.f
hdl/accel_pkg.sv
hdl/accel_ctrl_pkg.sv
hdl/input_pipe.sv
hdl/conv_engine.sv
hdl/lrelu_engine.sv
hdl/maxpool_engine.sv
hdl/axis_accelerator.sv
test/axis_accelerator_assert.sv
test/axis_accelerator_tb.sv

// File: hdl/accel_ctrl_pkg.sv
`default_nettype none

package accel_ctrl_pkg;

  // width of the tap count
  parameter int TAPS_BITS = 4;

  // config beat, sits in the low bits of weight word 0
  typedef struct packed {
    logic                 is_max;
    logic                 is_lrelu;
    logic [TAPS_BITS-1:0] taps_m1;
  } layer_cfg_t;

  // flags that ride along with every item
  typedef struct packed {
    logic is_lrelu;
    logic is_max;
    // final window of the layer
    logic last;
  } item_flags_t;

  // input pipe states
  typedef enum logic {
    ST_CONFIG,
    ST_RUN
  } pipe_state_e;

endpackage

`default_nettype wire

// File: hdl/accel_pkg.sv
`default_nettype none

package accel_pkg;

  // pixels handled side by side in one beat
  parameter int UNITS = 4;

  // signed pixel, weight and result width
  parameter int WORD_WIDTH = 8;

  // wide enough for a full window of 8x8 products
  parameter int ACC_WIDTH = 24;

  // one signed word
  typedef logic signed [WORD_WIDTH-1:0] word_t;

  // one signed accumulator
  typedef logic signed [ACC_WIDTH-1:0] acc_t;

  // pixel, weight or output data, word 0 in the low bits
  typedef word_t [UNITS-1:0] pix_vec_t;

  // one accumulator per unit
  typedef acc_t [UNITS-1:0] acc_vec_t;

  // one bit per output word
  typedef logic [UNITS-1:0] keep_t;

endpackage

`default_nettype wire

// File: hdl/axis_accelerator.sv
`timescale 1ns/100ps
`default_nettype none

module axis_accelerator #(
  parameter int KERNEL_MAX  = 9,
  parameter int LRELU_SHIFT = 3
) (
  input  wire                        aclk,
  input  wire                        rst,
  input  wire                        s_axis_pixels_tvalid,
  output wire                        s_axis_pixels_tready,
  input  wire  accel_pkg::pix_vec_t  s_axis_pixels_tdata,
  input  wire                        s_axis_weights_tvalid,
  output wire                        s_axis_weights_tready,
  input  wire                        s_axis_weights_tlast,
  input  wire  accel_pkg::pix_vec_t  s_axis_weights_tdata,
  output wire                        m_axis_tvalid,
  input  wire                        m_axis_tready,
  output wire  accel_pkg::pix_vec_t  m_axis_tdata,
  output wire  accel_pkg::keep_t     m_axis_tkeep,
  output wire                        m_axis_tlast
);

  import accel_pkg::*;
  import accel_ctrl_pkg::*;

  // input pipe to conv
  logic        pipe_valid;
  logic        pipe_ready;
  pix_vec_t    pipe_pixels;
  pix_vec_t    pipe_weights;
  logic        pipe_tap_last;
  item_flags_t pipe_flags;

  // conv to leaky relu
  logic        conv_valid;
  logic        conv_ready;
  acc_vec_t    conv_data;
  item_flags_t conv_flags;

  // leaky relu to max pool
  logic        lrelu_valid;
  logic        lrelu_ready;
  pix_vec_t    lrelu_data;
  item_flags_t lrelu_flags;

  input_pipe #(
    .KERNEL_MAX (KERNEL_MAX)
  ) input_pipe_i (
    .aclk                  (aclk                 ),
    .rst                   (rst                  ),
    .s_axis_pixels_tvalid  (s_axis_pixels_tvalid ),
    .s_axis_pixels_tready  (s_axis_pixels_tready ),
    .s_axis_pixels_tdata   (s_axis_pixels_tdata  ),
    .s_axis_weights_tvalid (s_axis_weights_tvalid),
    .s_axis_weights_tready (s_axis_weights_tready),
    .s_axis_weights_tlast  (s_axis_weights_tlast ),
    .s_axis_weights_tdata  (s_axis_weights_tdata ),
    .m_valid               (pipe_valid           ),
    .m_ready               (pipe_ready           ),
    .m_pixels              (pipe_pixels          ),
    .m_weights             (pipe_weights         ),
    .m_tap_last            (pipe_tap_last        ),
    .m_flags               (pipe_flags           )
  );

  conv_engine conv_engine_i (
    .aclk       (aclk         ),
    .rst        (rst          ),
    .s_valid    (pipe_valid   ),
    .s_ready    (pipe_ready   ),
    .s_pixels   (pipe_pixels  ),
    .s_weights  (pipe_weights ),
    .s_tap_last (pipe_tap_last),
    .s_flags    (pipe_flags   ),
    .m_valid    (conv_valid   ),
    .m_ready    (conv_ready   ),
    .m_data     (conv_data    ),
    .m_flags    (conv_flags   )
  );

  lrelu_engine #(
    .LRELU_SHIFT (LRELU_SHIFT)
  ) lrelu_engine_i (
    .aclk    (aclk       ),
    .rst     (rst        ),
    .s_valid (conv_valid ),
    .s_ready (conv_ready ),
    .s_data  (conv_data  ),
    .s_flags (conv_flags ),
    .m_valid (lrelu_valid),
    .m_ready (lrelu_ready),
    .m_data  (lrelu_data ),
    .m_flags (lrelu_flags)
  );

  maxpool_engine maxpool_engine_i (
    .aclk    (aclk         ),
    .rst     (rst          ),
    .s_valid (lrelu_valid  ),
    .s_ready (lrelu_ready  ),
    .s_data  (lrelu_data   ),
    .s_flags (lrelu_flags  ),
    .m_valid (m_axis_tvalid),
    .m_ready (m_axis_tready),
    .m_data  (m_axis_tdata ),
    .m_keep  (m_axis_tkeep ),
    .m_last  (m_axis_tlast )
  );

endmodule

`default_nettype wire

// File: hdl/conv_engine.sv
`timescale 1ns/100ps
`default_nettype none

module conv_engine (
  input  wire                          aclk,
  input  wire                          rst,
  input  wire                          s_valid,
  output logic                         s_ready,
  input  wire  accel_pkg::pix_vec_t    s_pixels,
  input  wire  accel_pkg::pix_vec_t    s_weights,
  input  wire                          s_tap_last,
  input  wire  accel_ctrl_pkg::item_flags_t s_flags,
  output logic                         m_valid,
  input  wire                          m_ready,
  output accel_pkg::acc_vec_t          m_data,
  output accel_ctrl_pkg::item_flags_t  m_flags
);

  import accel_pkg::*;
  import accel_ctrl_pkg::*;

  acc_vec_t    acc;
  acc_vec_t    acc_base;
  acc_vec_t    acc_next;
  item_flags_t acc_flags;
  logic        acc_done;
  logic        move;
  logic        take;
  logic signed [2*WORD_WIDTH-1:0] prod [UNITS];

  // a finished sum leaves as soon as the output register frees up
  assign move    = acc_done && (!m_valid || m_ready);
  // next window may start filling in the cycle the sum moves out
  assign s_ready = !acc_done || move;
  assign take    = s_valid && s_ready;

  always_comb begin
    for (int i = 0; i < UNITS; i++) begin
      prod[i]     = s_pixels[i] * s_weights[i];
      acc_base[i] = move ? '0 : acc[i];
      acc_next[i] = acc_base[i] + prod[i];
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      acc      <= '0;
      acc_done <= 1'b0;
      m_valid  <= 1'b0;
    end else begin
      if (take) begin
        acc <= acc_next;
      end else if (move) begin
        acc <= '0;
      end
      // one-tap windows can finish in the same cycle the last sum leaves
      if (take && s_tap_last) begin
        acc_done <= 1'b1;
      end else if (move) begin
        acc_done <= 1'b0;
      end
      if (move) begin
        m_valid <= 1'b1;
      end else if (m_ready) begin
        m_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (take && s_tap_last) begin
      acc_flags <= s_flags;
    end
    if (move) begin
      m_data  <= acc;
      m_flags <= acc_flags;
    end
  end

endmodule

`default_nettype wire

// File: hdl/input_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module input_pipe #(
  parameter int KERNEL_MAX = 9
) (
  input  wire                          aclk,
  input  wire                          rst,
  input  wire                          s_axis_pixels_tvalid,
  output logic                         s_axis_pixels_tready,
  input  wire  accel_pkg::pix_vec_t    s_axis_pixels_tdata,
  input  wire                          s_axis_weights_tvalid,
  output logic                         s_axis_weights_tready,
  input  wire                          s_axis_weights_tlast,
  input  wire  accel_pkg::pix_vec_t    s_axis_weights_tdata,
  output logic                         m_valid,
  input  wire                          m_ready,
  output accel_pkg::pix_vec_t          m_pixels,
  output accel_pkg::pix_vec_t          m_weights,
  output logic                         m_tap_last,
  output accel_ctrl_pkg::item_flags_t  m_flags
);

  import accel_ctrl_pkg::*;

  localparam logic [TAPS_BITS-1:0] TAPS_M1_MAX = TAPS_BITS'(KERNEL_MAX - 1);

  pipe_state_e          state;
  layer_cfg_t           cfg;
  layer_cfg_t           cfg_in;
  logic [TAPS_BITS-1:0] tap_cnt;
  logic                 can_load;
  logic                 fire;
  logic                 tap_last;

  // config fields from weight word 0, tap count clipped to the kernel size
  always_comb begin
    cfg_in = layer_cfg_t'(s_axis_weights_tdata[0][$bits(layer_cfg_t)-1:0]);
    if (cfg_in.taps_m1 > TAPS_M1_MAX) begin
      cfg_in.taps_m1 = TAPS_M1_MAX;
    end
  end

  assign can_load = !m_valid || m_ready;

  // both streams move together, each ready waits on the other's valid
  always_comb begin
    if (state == ST_CONFIG) begin
      s_axis_pixels_tready  = 1'b0;
      s_axis_weights_tready = 1'b1;
    end else begin
      s_axis_pixels_tready  = s_axis_weights_tvalid && can_load;
      s_axis_weights_tready = s_axis_pixels_tvalid && can_load;
    end
  end

  assign fire     = (state == ST_RUN) && s_axis_pixels_tvalid && s_axis_weights_tvalid
                    && can_load;
  assign tap_last = (tap_cnt == cfg.taps_m1);

  always_ff @(posedge aclk) begin
    if (rst) begin
      state   <= ST_CONFIG;
      tap_cnt <= '0;
      m_valid <= 1'b0;
    end else begin
      if (state == ST_CONFIG) begin
        if (s_axis_weights_tvalid) begin
          state   <= ST_RUN;
          tap_cnt <= '0;
        end
      end else if (fire) begin
        tap_cnt <= tap_last ? '0 : tap_cnt + 1'b1;
        // weight tlast on the closing pair ends the layer
        if (tap_last && s_axis_weights_tlast) begin
          state <= ST_CONFIG;
        end
      end
      if (fire) begin
        m_valid <= 1'b1;
      end else if (m_ready) begin
        m_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (state == ST_CONFIG && s_axis_weights_tvalid) begin
      cfg <= cfg_in;
    end
    if (fire) begin
      m_pixels         <= s_axis_pixels_tdata;
      m_weights        <= s_axis_weights_tdata;
      m_tap_last       <= tap_last;
      m_flags.is_lrelu <= cfg.is_lrelu;
      m_flags.is_max   <= cfg.is_max;
      m_flags.last     <= tap_last && s_axis_weights_tlast;
    end
  end

endmodule

`default_nettype wire

// File: hdl/lrelu_engine.sv
`timescale 1ns/100ps
`default_nettype none

module lrelu_engine #(
  parameter int LRELU_SHIFT = 3
) (
  input  wire                          aclk,
  input  wire                          rst,
  input  wire                          s_valid,
  output logic                         s_ready,
  input  wire  accel_pkg::acc_vec_t    s_data,
  input  wire  accel_ctrl_pkg::item_flags_t s_flags,
  output logic                         m_valid,
  input  wire                          m_ready,
  output accel_pkg::pix_vec_t          m_data,
  output accel_ctrl_pkg::item_flags_t  m_flags
);

  import accel_pkg::*;

  // signed word range
  localparam word_t WORD_HI = word_t'(2**(WORD_WIDTH-1) - 1);
  localparam word_t WORD_LO = word_t'(-(2**(WORD_WIDTH-1)));

  acc_vec_t scaled;
  pix_vec_t clamped;

  always_comb begin
    for (int i = 0; i < UNITS; i++) begin
      // alpha = 2^-LRELU_SHIFT on the negative side
      scaled[i] = (s_flags.is_lrelu && s_data[i] < 0) ? s_data[i] >>> LRELU_SHIFT : s_data[i];
      if (scaled[i] > WORD_HI) begin
        clamped[i] = WORD_HI;
      end else if (scaled[i] < WORD_LO) begin
        clamped[i] = WORD_LO;
      end else begin
        clamped[i] = scaled[i][WORD_WIDTH-1:0];
      end
    end
  end

  assign s_ready = !m_valid || m_ready;

  always_ff @(posedge aclk) begin
    if (rst) begin
      m_valid <= 1'b0;
    end else if (s_valid && s_ready) begin
      m_valid <= 1'b1;
    end else if (m_ready) begin
      m_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (s_valid && s_ready) begin
      m_data  <= clamped;
      m_flags <= s_flags;
    end
  end

endmodule

`default_nettype wire

// File: hdl/maxpool_engine.sv
`timescale 1ns/100ps
`default_nettype none

module maxpool_engine (
  input  wire                          aclk,
  input  wire                          rst,
  input  wire                          s_valid,
  output logic                         s_ready,
  input  wire  accel_pkg::pix_vec_t    s_data,
  input  wire  accel_ctrl_pkg::item_flags_t s_flags,
  output logic                         m_valid,
  input  wire                          m_ready,
  output accel_pkg::pix_vec_t          m_data,
  output accel_pkg::keep_t             m_keep,
  output logic                         m_last
);

  import accel_pkg::*;

  pix_vec_t pool_data;
  keep_t    pool_keep;

  always_comb begin
    pool_data = s_data;
    pool_keep = '1;
    if (s_flags.is_max) begin
      // neighbouring units pair up, results pack into the low half
      pool_data = '0;
      pool_keep = '0;
      for (int i = 0; i < UNITS/2; i++) begin
        if (s_data[2*i] > s_data[2*i+1]) begin
          pool_data[i] = s_data[2*i];
        end else begin
          pool_data[i] = s_data[2*i+1];
        end
        pool_keep[i] = 1'b1;
      end
    end
  end

  assign s_ready = !m_valid || m_ready;

  always_ff @(posedge aclk) begin
    if (rst) begin
      m_valid <= 1'b0;
    end else if (s_valid && s_ready) begin
      m_valid <= 1'b1;
    end else if (m_ready) begin
      m_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (s_valid && s_ready) begin
      m_data <= pool_data;
      m_keep <= pool_keep;
      m_last <= s_flags.last;
    end
  end

endmodule

`default_nettype wire

// File: test/axis_accelerator_assert.sv
`timescale 1ns/100ps
`default_nettype none

module axis_accelerator_assert (
  input wire                       aclk,
  input wire                       rst,
  input wire                       s_axis_pixels_tvalid,
  input wire                       s_axis_pixels_tready,
  input wire                       s_axis_weights_tvalid,
  input wire                       m_axis_tvalid,
  input wire                       m_axis_tready,
  input wire accel_pkg::pix_vec_t  m_axis_tdata,
  input wire accel_pkg::keep_t     m_axis_tkeep,
  input wire                       m_axis_tlast
);

  int unsigned error_count = 0;

  // payload frozen while stalled
  payload_stable: assert property (@(posedge aclk) disable iff (rst)
    m_axis_tvalid && !m_axis_tready |=>
      $stable(m_axis_tdata) && $stable(m_axis_tkeep) && $stable(m_axis_tlast))
    else begin
      $error("m_axis payload changed while stalled");
      error_count++;
    end

  valid_held: assert property (@(posedge aclk) disable iff (rst)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid)
    else begin
      $error("m_axis_tvalid dropped before acceptance");
      error_count++;
    end

  // quiet outputs right after reset
  reset_quiet: assert property (@(posedge aclk)
    rst |=> !m_axis_tvalid && !s_axis_pixels_tready)
    else begin
      $error("valid or pixel ready high in the cycle after reset");
      error_count++;
    end

  // pixel beats only move together with a weight beat
  pixels_joined: assert property (@(posedge aclk) disable iff (rst)
    !s_axis_weights_tvalid |-> !(s_axis_pixels_tready && s_axis_pixels_tvalid))
    else begin
      $error("pixel beat accepted without a weight beat");
      error_count++;
    end

endmodule

bind axis_accelerator axis_accelerator_assert assert_i (.*);

`default_nettype wire

// File: test/axis_accelerator_tb.sv
`timescale 1ns/100ps
`default_nettype none

module axis_accelerator_tb;

  import accel_pkg::*;
  import accel_ctrl_pkg::*;

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 5;
  localparam int KERNEL_MAX    = 9;
  localparam int LRELU_SHIFT   = 3;
  localparam int TOTAL_WINDOWS = 17;
  localparam logic [31:0] SEED = 32'hd161_1246;
  localparam int WORD_MAX = (1 << (WORD_WIDTH-1)) - 1;
  localparam int WORD_MIN = -(1 << (WORD_WIDTH-1));

  // one expected output beat
  typedef struct packed {
    pix_vec_t data;
    keep_t    keep;
    logic     last;
  } result_t;

  logic     aclk = 1'b0;
  logic     rst;
  logic     s_axis_pixels_tvalid;
  wire      s_axis_pixels_tready;
  pix_vec_t s_axis_pixels_tdata;
  logic     s_axis_weights_tvalid;
  wire      s_axis_weights_tready;
  logic     s_axis_weights_tlast;
  pix_vec_t s_axis_weights_tdata;
  wire      m_axis_tvalid;
  logic     m_axis_tready;
  pix_vec_t m_axis_tdata;
  keep_t    m_axis_tkeep;
  wire      m_axis_tlast;

  logic [31:0] stim_seed;
  logic [31:0] ready_seed;
  logic        random_ready;
  result_t     exp_q [$];
  int          results_seen;

  axis_accelerator #(
    .KERNEL_MAX  (KERNEL_MAX ),
    .LRELU_SHIFT (LRELU_SHIFT)
  ) dut_i (
    .aclk                  (aclk                 ),
    .rst                   (rst                  ),
    .s_axis_pixels_tvalid  (s_axis_pixels_tvalid ),
    .s_axis_pixels_tready  (s_axis_pixels_tready ),
    .s_axis_pixels_tdata   (s_axis_pixels_tdata  ),
    .s_axis_weights_tvalid (s_axis_weights_tvalid),
    .s_axis_weights_tready (s_axis_weights_tready),
    .s_axis_weights_tlast  (s_axis_weights_tlast ),
    .s_axis_weights_tdata  (s_axis_weights_tdata ),
    .m_axis_tvalid         (m_axis_tvalid        ),
    .m_axis_tready         (m_axis_tready        ),
    .m_axis_tdata          (m_axis_tdata         ),
    .m_axis_tkeep          (m_axis_tkeep         ),
    .m_axis_tlast          (m_axis_tlast         )
  );

  always #(CLK_PERIOD/2) aclk = ~aclk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_stim();
    stim_seed = lcg_step(stim_seed);
    return stim_seed;
  endfunction

  // shift by 0..3 so small and large magnitudes both show up
  function automatic word_t rand_word(input logic [31:0] r);
    return word_t'($signed(r[23:16]) >>> r[25:24]);
  endfunction

  task automatic stop_with_failure();
    $display(">>> FAIL");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic drive_config(input int taps, input logic lrelu, input logic max);
    layer_cfg_t cfg;
    cfg.taps_m1  = TAPS_BITS'(taps - 1);
    cfg.is_lrelu = lrelu;
    cfg.is_max   = max;
    @(negedge aclk);
    s_axis_pixels_tvalid    = 1'b0;
    s_axis_weights_tvalid   = 1'b1;
    s_axis_weights_tlast    = 1'b0;
    s_axis_weights_tdata    = '0;
    s_axis_weights_tdata[0] = word_t'(cfg);
    do begin
      @(posedge aclk);
    end while (!s_axis_weights_tready);
  endtask

  task automatic send_pair(input pix_vec_t pix, input pix_vec_t wgt, input logic last);
    logic [31:0] r;
    r = next_stim();
    @(negedge aclk);
    if (r[1:0] == 2'd0) begin
      // idle gap
      s_axis_pixels_tvalid  = 1'b0;
      s_axis_weights_tvalid = 1'b0;
      @(negedge aclk);
    end else if (r[1:0] == 2'd1) begin
      // pixel beat shows up a cycle before its weight
      s_axis_pixels_tvalid  = 1'b1;
      s_axis_pixels_tdata   = pix;
      s_axis_weights_tvalid = 1'b0;
      @(negedge aclk);
    end
    s_axis_pixels_tvalid  = 1'b1;
    s_axis_pixels_tdata   = pix;
    s_axis_weights_tvalid = 1'b1;
    s_axis_weights_tdata  = wgt;
    s_axis_weights_tlast  = last;
    do begin
      @(posedge aclk);
    end while (!(s_axis_pixels_tready && s_axis_weights_tready));
  endtask

  // sends one window and queues its expected result
  task automatic send_window(input int taps, input logic lrelu, input logic max,
                             input logic last);
    int          sum [UNITS];
    int          v;
    pix_vec_t    pix;
    pix_vec_t    wgt;
    pix_vec_t    act;
    result_t     res;
    for (int i = 0; i < UNITS; i++) begin
      sum[i] = 0;
    end
    for (int t = 0; t < taps; t++) begin
      for (int i = 0; i < UNITS; i++) begin
        pix[i] = rand_word(next_stim());
        wgt[i] = rand_word(next_stim());
        sum[i] = sum[i] + int'(pix[i]) * int'(wgt[i]);
      end
      send_pair(pix, wgt, last && (t == taps - 1));
    end
    for (int i = 0; i < UNITS; i++) begin
      v = sum[i];
      if (lrelu && v < 0) begin
        v = v >>> LRELU_SHIFT;
      end
      if (v > WORD_MAX) begin
        v = WORD_MAX;
      end else if (v < WORD_MIN) begin
        v = WORD_MIN;
      end
      act[i] = word_t'(v);
    end
    if (max) begin
      res.data = '0;
      res.keep = '0;
      for (int i = 0; i < UNITS/2; i++) begin
        res.data[i] = (act[2*i] > act[2*i+1]) ? act[2*i] : act[2*i+1];
        res.keep[i] = 1'b1;
      end
    end else begin
      res.data = act;
      res.keep = '1;
    end
    res.last = last;
    exp_q.push_back(res);
  endtask

  task automatic send_layer(input int taps, input logic lrelu, input logic max,
                            input int windows);
    drive_config(taps, lrelu, max);
    for (int w = 0; w < windows; w++) begin
      send_window(taps, lrelu, max, w == windows - 1);
    end
  endtask

  // output sink, held ready or random
  always @(negedge aclk) begin
    if (random_ready) begin
      ready_seed    = lcg_step(ready_seed);
      m_axis_tready = (ready_seed[31:30] != 2'b00);
    end else begin
      m_axis_tready = 1'b1;
    end
  end

  always @(posedge aclk) begin : output_monitor
    result_t expected;
    if (!rst && m_axis_tvalid && m_axis_tready) begin
      if (exp_q.size() == 0) begin
        $display("output beat arrived while no result was expected at %0t ns", $time);
        stop_with_failure();
      end else begin
        expected = exp_q.pop_front();
        check_value("m_axis_tdata", expected.data, m_axis_tdata);
        check_value("m_axis_tkeep", expected.keep, m_axis_tkeep);
        check_value("m_axis_tlast", expected.last, m_axis_tlast);
        results_seen++;
      end
    end
  end

  always @(posedge aclk) begin
    if (dut_i.assert_i.error_count != 0) begin
      $display("a bound handshake assertion failed at %0t ns", $time);
      stop_with_failure();
    end
  end

  initial begin
    #(TOTAL_WINDOWS * (KERNEL_MAX + 8) * 8 * CLK_PERIOD);
    $display("timeout with %0d of %0d results received", results_seen, TOTAL_WINDOWS);
    stop_with_failure();
  end

  initial begin : stimulus
    logic [31:0] r;
    rst                   = 1'b1;
    s_axis_pixels_tvalid  = 1'b0;
    s_axis_pixels_tdata   = '0;
    s_axis_weights_tvalid = 1'b0;
    s_axis_weights_tlast  = 1'b0;
    s_axis_weights_tdata  = '0;
    m_axis_tready         = 1'b1;
    random_ready          = 1'b0;
    stim_seed             = SEED;
    ready_seed            = SEED;
    results_seen          = 0;
    repeat (RESET_CYCLES) @(posedge aclk);
    @(negedge aclk);
    rst = 1'b0;

    // stray pixel valids before any config beat
    repeat (8) begin
      @(negedge aclk);
      r = next_stim();
      s_axis_pixels_tvalid = r[4];
      s_axis_pixels_tdata  = r;
      @(posedge aclk);
      check_value("m_axis_tvalid", 32'd0, m_axis_tvalid);
      check_value("s_axis_pixels_tready", 32'd0, s_axis_pixels_tready);
      check_value("s_axis_weights_tready", 32'd1, s_axis_weights_tready);
    end

    // plain convolution, output always ready
    send_layer(1, 1'b0, 1'b0, 3);
    send_layer(3, 1'b0, 1'b0, 3);
    send_layer(9, 1'b0, 1'b0, 2);

    // three layers back to back under back-pressure
    random_ready = 1'b1;
    send_layer(3, 1'b1, 1'b0, 4);
    send_layer(2, 1'b0, 1'b1, 3);
    send_layer(9, 1'b1, 1'b1, 2);

    @(negedge aclk);
    s_axis_pixels_tvalid  = 1'b0;
    s_axis_weights_tvalid = 1'b0;
    s_axis_weights_tlast  = 1'b0;

    wait (results_seen == TOTAL_WINDOWS);
    repeat (10) @(posedge aclk);
    if (exp_q.size() == 0 && dut_i.assert_i.error_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("results left over or handshake assertion failed");
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire
